/* source/sparse_tile_macros.svh */
`ifndef SPARSE_TILE_MACROS_SVH
`define SPARSE_TILE_MACROS_SVH

// output tile side, row and column indices
`define TILE_DIM 16

// largest kernel offset plus one
`define KERNEL_DIM 3

// weights and activations per operand group
`define LANES 4

// accumulator banks, selected by low column bits
`define BANK_COUNT 8

// entries per bank
`define BANK_DEPTH ((`TILE_DIM * `TILE_DIM) / `BANK_COUNT)

// signed operand width
`define VALUE_W 8

// signed accumulator width, wraps on overflow
`define ACC_W 24

`endif

/* source/sparse_tile_pkg.sv */
`default_nettype none

`include "sparse_tile_macros.svh"

package sparse_tile_pkg;

    // field widths derived from the tile geometry
    localparam int COORD_W = $clog2(`TILE_DIM);
    localparam int OFFSET_W = $clog2(`KERNEL_DIM);
    localparam int BANK_W = $clog2(`BANK_COUNT);
    localparam int ENTRY_W = $clog2(`BANK_DEPTH);
    localparam int PROD_W = 2 * `VALUE_W;
    localparam int ADDR_W = 2 * COORD_W;
    localparam int PRODUCTS = `LANES * `LANES;

    // one nonzero weight with its kernel offset
    typedef struct packed {
        logic valid;
        logic signed [`VALUE_W-1:0] value;
        logic [OFFSET_W-1:0] r;
        logic [OFFSET_W-1:0] s;
    } weight_elem_t;

    // one nonzero activation with its tile position
    typedef struct packed {
        logic valid;
        logic signed [`VALUE_W-1:0] value;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
    } act_elem_t;

    // operand group handed over per req/ack cycle
    typedef struct packed {
        weight_elem_t [`LANES-1:0] weights;
        act_elem_t [`LANES-1:0] acts;
    } operand_group_t;

    // one product already steered to bank and entry
    typedef struct packed {
        logic valid;
        logic [BANK_W-1:0] bank;
        logic [ENTRY_W-1:0] entry;
        logic signed [PROD_W-1:0] value;
    } product_t;

    // index is weight lane * LANES + activation lane
    typedef product_t [PRODUCTS-1:0] product_set_t;

    // write port of one accumulator bank
    typedef struct packed {
        logic enable;
        logic [ENTRY_W-1:0] entry;
        logic signed [PROD_W-1:0] value;
    } bank_write_t;

endpackage

`default_nettype wire

/* source/cartesian_product_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sparse_tile_macros.svh"

module cartesian_product_unit (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          operand_req,
    input  sparse_tile_pkg::operand_group_t operand_group,
    output logic                          operand_ack,
    input  logic                          crossbar_ready,
    output sparse_tile_pkg::product_set_t products,
    output logic                          products_valid
);
    import sparse_tile_pkg::*;

    // coordinate sums need one extra bit to spot tile overflow
    localparam int SUM_W = COORD_W + 1;

    product_set_t next_products;
    logic set_moves;
    logic take;

    // held set leaves this edge
    assign set_moves = products_valid && crossbar_ready;

    // new group only on a fresh req, and only into a free stage
    assign take = operand_req && !operand_ack && (!products_valid || crossbar_ready);

    // all weight x activation pairs with their output coordinates
    always_comb begin
        logic [SUM_W-1:0] out_row;
        logic [SUM_W-1:0] out_col;
        weight_elem_t wt;
        act_elem_t act;
        for (int w = 0; w < `LANES; w++) begin
            for (int a = 0; a < `LANES; a++) begin
                wt = operand_group.weights[w];
                act = operand_group.acts[a];
                out_row = SUM_W'(act.row) + SUM_W'(wt.r);
                out_col = SUM_W'(act.col) + SUM_W'(wt.s);
                // masked lane or sum past the tile edge drops the pair
                next_products[w*`LANES + a].valid = wt.valid && act.valid &&
                    (out_row < SUM_W'(`TILE_DIM)) && (out_col < SUM_W'(`TILE_DIM));
                // bank from low column bits
                next_products[w*`LANES + a].bank = out_col[BANK_W-1:0];
                // entry is row, then the column bits above the bank
                next_products[w*`LANES + a].entry =
                    {out_row[COORD_W-1:0], out_col[COORD_W-1:BANK_W]};
                next_products[w*`LANES + a].value =
                    $signed(wt.value) * $signed(act.value);
            end
        end
    end

    // handshake and stage occupancy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            operand_ack <= 1'b0;
            products_valid <= 1'b0;
        end else begin
            // ack up with the register load, down once req is gone
            if (take) begin
                operand_ack <= 1'b1;
            end else if (!operand_req) begin
                operand_ack <= 1'b0;
            end
            if (take) begin
                products_valid <= 1'b1;
            end else if (set_moves) begin
                products_valid <= 1'b0;
            end
        end
    end

    // product set payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            products <= next_products;
        end
    end

endmodule

`default_nettype wire

/* source/bank_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sparse_tile_macros.svh"

module bank_crossbar (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  sparse_tile_pkg::product_set_t                 products,
    input  logic                                          products_valid,
    output logic                                          crossbar_ready,
    output sparse_tile_pkg::bank_write_t [`BANK_COUNT-1:0] bank_writes,
    output logic                                          drained
);
    import sparse_tile_pkg::*;

    product_set_t held;
    logic [PRODUCTS-1:0] pending;
    logic [PRODUCTS-1:0] incoming_mask;
    logic [PRODUCTS-1:0] issued;
    logic [`BANK_COUNT-1:0] claimed;
    logic [`BANK_COUNT-1:0] write_busy;
    bank_write_t [`BANK_COUNT-1:0] next_writes;
    logic accept;

    // new set only once the previous one is fully issued
    assign crossbar_ready = (pending == '0);
    assign accept = products_valid && crossbar_ready;

    // valid lanes of the incoming set become the pending mask
    always_comb begin
        for (int p = 0; p < PRODUCTS; p++) begin
            incoming_mask[p] = products[p].valid;
        end
    end

    // registered write port still carrying something
    always_comb begin
        for (int b = 0; b < `BANK_COUNT; b++) begin
            write_busy[b] = bank_writes[b].enable;
        end
    end

    // nothing held, nothing in flight, nothing arriving
    assign drained = crossbar_ready && (write_busy == '0) && !products_valid;

    // per bank, lowest pending product wins
    // the rest stay pending, which is the conflict stall
    always_comb begin
        next_writes = '0;
        issued = '0;
        claimed = '0;
        for (int p = 0; p < PRODUCTS; p++) begin
            if (pending[p] && !claimed[held[p].bank]) begin
                claimed[held[p].bank] = 1'b1;
                issued[p] = 1'b1;
                next_writes[held[p].bank].enable = 1'b1;
                next_writes[held[p].bank].entry = held[p].entry;
                next_writes[held[p].bank].value = held[p].value;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= '0;
            bank_writes <= '0;
        end else begin
            // banks see the write one cycle after issue
            bank_writes <= next_writes;
            if (accept) begin
                pending <= incoming_mask;
            end else begin
                pending <= pending & ~issued;
            end
        end
    end

    // accepted set payload
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= products;
        end
    end

endmodule

`default_nettype wire

/* source/accumulator_banks.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sparse_tile_macros.svh"

module accumulator_banks (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  sparse_tile_pkg::bank_write_t [`BANK_COUNT-1:0] bank_writes,
    input  logic                                          drained,
    input  logic                                          transfer_req,
    output logic                                          transfer_ack,
    input  logic [sparse_tile_pkg::ADDR_W-1:0]            read_addr,
    output logic signed [`ACC_W-1:0]                     read_data
);
    import sparse_tile_pkg::*;

    // two buffers, front_sel names the one taking writes
    logic signed [`ACC_W-1:0] acc [2][`BANK_COUNT][`BANK_DEPTH];
    logic front_sel;
    logic swap;
    logic [BANK_W-1:0] read_bank;
    logic [ENTRY_W-1:0] read_entry;

    // swap only with no product left upstream
    assign swap = transfer_req && !transfer_ack && drained;

    // address is row*TILE_DIM + col, low column bits pick the bank
    assign read_bank = read_addr[BANK_W-1:0];
    assign read_entry = read_addr[ADDR_W-1:BANK_W];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            front_sel <= 1'b0;
            transfer_ack <= 1'b0;
            read_data <= '0;
            for (int f = 0; f < 2; f++) begin
                for (int b = 0; b < `BANK_COUNT; b++) begin
                    for (int e = 0; e < `BANK_DEPTH; e++) begin
                        acc[f][b][e] <= '0;
                    end
                end
            end
        end else begin
            // readout always from the back buffer
            read_data <= acc[!front_sel][read_bank][read_entry];
            // front accumulate, sign extended and wrapping
            for (int b = 0; b < `BANK_COUNT; b++) begin
                if (bank_writes[b].enable) begin
                    acc[front_sel][b][bank_writes[b].entry] <=
                        acc[front_sel][b][bank_writes[b].entry] +
                        `ACC_W'(bank_writes[b].value);
                end
            end
            if (swap) begin
                front_sel <= !front_sel;
                transfer_ack <= 1'b1;
                // old back becomes the new front, starts empty
                for (int b = 0; b < `BANK_COUNT; b++) begin
                    for (int e = 0; e < `BANK_DEPTH; e++) begin
                        acc[!front_sel][b][e] <= '0;
                    end
                end
            end else if (!transfer_req) begin
                transfer_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/sparse_tile_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sparse_tile_macros.svh"

module sparse_tile_top (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               operand_req,
    input  sparse_tile_pkg::operand_group_t    operand_group,
    output logic                               operand_ack,
    input  logic                               transfer_req,
    output logic                               transfer_ack,
    input  logic [sparse_tile_pkg::ADDR_W-1:0] read_addr,
    output logic signed [`ACC_W-1:0]           read_data
);
    import sparse_tile_pkg::*;

    // product stream
    product_set_t products;
    logic products_valid;
    logic crossbar_ready;

    // crossbar to banks
    bank_write_t [`BANK_COUNT-1:0] bank_writes;
    logic drained;

    // operand handshake, multiplies, coordinates
    cartesian_product_unit cartesian_product_unit_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .operand_req    (operand_req),
        .operand_group  (operand_group),
        .operand_ack    (operand_ack),
        .crossbar_ready (crossbar_ready),
        .products       (products),
        .products_valid (products_valid)
    );

    // bank conflict resolution
    bank_crossbar bank_crossbar_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .products       (products),
        .products_valid (products_valid),
        .crossbar_ready (crossbar_ready),
        .bank_writes    (bank_writes),
        .drained        (drained)
    );

    // double-buffered sums and readout
    accumulator_banks accumulator_banks_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .bank_writes  (bank_writes),
        .drained      (drained),
        .transfer_req (transfer_req),
        .transfer_ack (transfer_ack),
        .read_addr    (read_addr),
        .read_data    (read_data)
    );

endmodule

`default_nettype wire

/* verification/sparse_tile_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sparse_tile_checker (
    input logic clk,
    input logic reset_n,
    input logic operand_req,
    input logic operand_ack,
    input logic transfer_req,
    input logic transfer_ack,
    input logic products_valid,
    input logic crossbar_ready,
    input logic drained
);

    // number of assertion failures so far
    int unsigned failure_count = 0;

    // idle state held through reset
    reset_state: assert property (@(posedge clk)
        !reset_n |-> !operand_ack && !transfer_ack && !products_valid && crossbar_ready)
        else begin
            failure_count++;
            $error("handshake or stream state not idle during reset");
        end

    // operand ack goes up only in answer to a req
    operand_ack_rise: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(operand_ack) |-> $past(operand_req))
        else begin
            failure_count++;
            $error("operand_ack rose without operand_req");
        end

    // and comes down only once req is gone
    operand_ack_fall: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(operand_ack) |-> !$past(operand_req))
        else begin
            failure_count++;
            $error("operand_ack fell while operand_req was high");
        end

    // req may only drop after the ack
    operand_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(operand_req) |-> operand_ack)
        else begin
            failure_count++;
            $error("operand_req dropped before operand_ack");
        end

    transfer_ack_rise: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(transfer_ack) |-> $past(transfer_req) && $past(drained))
        else begin
            failure_count++;
            $error("transfer_ack rose without transfer_req or with products in flight");
        end

    transfer_ack_fall: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(transfer_ack) |-> !$past(transfer_req))
        else begin
            failure_count++;
            $error("transfer_ack fell while transfer_req was high");
        end

    transfer_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(transfer_req) |-> transfer_ack)
        else begin
            failure_count++;
            $error("transfer_req dropped before transfer_ack");
        end

endmodule

// attached to every instance of the tile top
bind sparse_tile_top sparse_tile_checker sparse_tile_checker_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .operand_req    (operand_req),
    .operand_ack    (operand_ack),
    .transfer_req   (transfer_req),
    .transfer_ack   (transfer_ack),
    .products_valid (products_valid),
    .crossbar_ready (crossbar_ready),
    .drained        (drained)
);

`default_nettype wire

/* verification/sparse_tile_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sparse_tile_macros.svh"

module sparse_tile_tb;
    import sparse_tile_pkg::*;

    // groups plus stalls plus three full readouts, with margin
    localparam int TIMEOUT_CYCLES = 30000;
    localparam int TILE_ENTRIES = `TILE_DIM * `TILE_DIM;

    logic clk;
    logic reset_n;
    logic operand_req;
    operand_group_t operand_group;
    logic operand_ack;
    logic transfer_req;
    logic transfer_ack;
    logic [ADDR_W-1:0] read_addr;
    logic signed [`ACC_W-1:0] read_data;

    // expected tile sums, indexed row*TILE_DIM + col
    logic signed [`ACC_W-1:0] model [TILE_ENTRIES];
    int cycle_count;

    sparse_tile_top sparse_tile_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .operand_req   (operand_req),
        .operand_group (operand_group),
        .operand_ack   (operand_ack),
        .transfer_req  (transfer_req),
        .transfer_ack  (transfer_ack),
        .read_addr     (read_addr),
        .read_data     (read_data)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic clear_model();
        for (int i = 0; i < TILE_ENTRIES; i++) begin
            model[i] = '0;
        end
    endtask

    // every valid pair that lands inside the tile adds to its output pixel
    task automatic add_to_model(input operand_group_t g);
        int out_row;
        int out_col;
        int prod;
        logic [ADDR_W-1:0] addr;
        for (int w = 0; w < `LANES; w++) begin
            for (int a = 0; a < `LANES; a++) begin
                out_row = int'(g.acts[a].row) + int'(g.weights[w].r);
                out_col = int'(g.acts[a].col) + int'(g.weights[w].s);
                if (g.weights[w].valid && g.acts[a].valid &&
                    out_row < `TILE_DIM && out_col < `TILE_DIM) begin
                    prod = int'($signed(g.weights[w].value)) * int'($signed(g.acts[a].value));
                    addr = ADDR_W'(out_row * `TILE_DIM + out_col);
                    // 24-bit wraparound like the accumulators
                    model[addr] = model[addr] + `ACC_W'(prod);
                end
            end
        end
    endtask

    // random masks and coordinates, offsets up to 3 so some sums leave the tile
    function automatic operand_group_t random_group();
        operand_group_t g;
        for (int i = 0; i < `LANES; i++) begin
            g.weights[i].valid = ($urandom_range(3) != 0);
            g.weights[i].value = `VALUE_W'($urandom);
            g.weights[i].r = OFFSET_W'($urandom);
            g.weights[i].s = OFFSET_W'($urandom);
            g.acts[i].valid = ($urandom_range(3) != 0);
            g.acts[i].value = `VALUE_W'($urandom);
            g.acts[i].row = COORD_W'($urandom);
            g.acts[i].col = COORD_W'($urandom);
        end
        return g;
    endfunction

    // all sixteen products aimed at bank 2, spread over its entries
    function automatic operand_group_t one_bank_group();
        operand_group_t g;
        for (int i = 0; i < `LANES; i++) begin
            g.weights[i].valid = 1'b1;
            g.weights[i].value = `VALUE_W'($urandom);
            g.weights[i].r = OFFSET_W'(i % 3);
            g.weights[i].s = '0;
            g.acts[i].valid = 1'b1;
            g.acts[i].value = `VALUE_W'($urandom);
            g.acts[i].row = COORD_W'(3 * i);
            g.acts[i].col = (i % 2 == 0) ? COORD_W'(2) : COORD_W'(10);
        end
        return g;
    endfunction

    // all sixteen products on a single entry, the longest stall
    function automatic operand_group_t one_entry_group();
        operand_group_t g;
        for (int i = 0; i < `LANES; i++) begin
            g.weights[i].valid = 1'b1;
            g.weights[i].value = `VALUE_W'($urandom);
            g.weights[i].r = '0;
            g.weights[i].s = '0;
            g.acts[i].valid = 1'b1;
            g.acts[i].value = `VALUE_W'($urandom);
            g.acts[i].row = COORD_W'(5);
            g.acts[i].col = COORD_W'(7);
        end
        return g;
    endfunction

    // four-phase operand handshake, entered 1 ns after an edge
    task automatic send_group(input operand_group_t g);
        operand_group = g;
        operand_req = 1'b1;
        add_to_model(g);
        do begin
            @(posedge clk);
            #1;
        end while (!operand_ack);
        operand_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (operand_ack);
    endtask

    task automatic run_transfer();
        transfer_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!transfer_ack);
        transfer_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (transfer_ack);
    endtask

    // back-to-back reads, each result checked one cycle after its address
    task automatic check_readout();
        logic [ADDR_W-1:0] last_addr;
        logic signed [`ACC_W-1:0] expected;
        for (int i = 0; i <= TILE_ENTRIES; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                last_addr = ADDR_W'(i - 1);
                expected = model[last_addr];
                assert (read_data == expected) else begin
                    $display("[ERROR] %0t read_data expected %0d actual %0d at address %0d",
                        $time, expected, read_data, last_addr);
                    fail_run("readout mismatch");
                end
            end
            if (i < TILE_ENTRIES) begin
                read_addr = ADDR_W'(i);
            end
        end
    endtask

    initial begin
        reset_n = 1'b0;
        operand_req = 1'b0;
        operand_group = '0;
        transfer_req = 1'b0;
        read_addr = '0;
        clear_model();
        void'($urandom(91));
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // back buffer straight out of reset
        check_readout();
        // first batch with the conflict groups mixed in
        for (int n = 0; n < 20; n++) begin
            send_group(random_group());
        end
        send_group(one_bank_group());
        send_group(one_entry_group());
        send_group(one_bank_group());
        send_group(one_entry_group());
        run_transfer();
        check_readout();
        clear_model();
        // empty swap makes the first batch's buffer the front again
        run_transfer();
        // second batch must not see anything of the first
        for (int n = 0; n < 16; n++) begin
            send_group(random_group());
        end
        run_transfer();
        check_readout();
        if (sparse_tile_top_inst.sparse_tile_checker_inst.failure_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            fail_run("a handshake or reset assertion failed");
        end
    end

    // watchdog, also stops at the first checker assertion failure
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            if (sparse_tile_top_inst.sparse_tile_checker_inst.failure_count != 0) begin
                fail_run("a handshake or reset assertion failed");
            end
            cycle_count++;
        end
        fail_run("simulation did not finish within the cycle limit");
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
source/sparse_tile_pkg.sv
source/cartesian_product_unit.sv
source/bank_crossbar.sv
source/accumulator_banks.sv
source/sparse_tile_top.sv
verification/sparse_tile_checker.sv
verification/sparse_tile_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --timescale 1ns/1ps --top-module sparse_tile_tb -f list.f

status=0
./obj_dir/Vsparse_tile_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "simulation failed (exit status ${status})"
exit 1
